//--- logic/cluster_pkg.sv
/*
 * Cluster control package
 * Sizes, register map, reset constants and shared types
 */
package cluster_pkg;

  // Cluster and bus dimensions
  localparam int unsigned NumCores     = 4;
  localparam int unsigned CoreIdxWidth = (NumCores > 1) ? $clog2(NumCores) : 1;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 5;

  // Modelled core run time in cycles
  localparam int unsigned WorkCycles  = 8;
  localparam int unsigned RunCntWidth = $clog2(WorkCycles + 1);

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [NumCores-1:0]    core_mask_t;
  typedef logic [RunCntWidth-1:0] run_cnt_t;

  // Shared TCDM placement
  localparam data_t TcdmBaseAddr = 32'h1000_0000;
  localparam data_t TcdmSize     = 32'h0001_0000;

  // Register map, byte offsets
  localparam addr_t EocOffset       = 5'h00;
  localparam addr_t WakeUpOffset    = 5'h04;
  localparam addr_t TcdmStartOffset = 5'h08;
  localparam addr_t TcdmEndOffset   = 5'h0C;
  localparam addr_t NumCoresOffset  = 5'h10;
  localparam addr_t DoneOffset      = 5'h14;

  // Reset values of the writable registers
  localparam data_t EocRstVal    = '0;
  localparam data_t WakeUpRstVal = '0;

  // Wake-up value that addresses every core
  localparam data_t WakeAll = '1;

  // Sleep unit states
  typedef enum logic {
    SLEEP,
    RUN
  } core_state_e;

endpackage

//--- logic/ctrl_registers.sv
`timescale 1ns/1ns

/*
 * Cluster control register file
 * Plain register bus, wake-up decode and end-of-computation outputs
 */
module ctrl_registers (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  cluster_pkg::addr_t      addr_i,
  input  cluster_pkg::data_t      wdata_i,
  input  cluster_pkg::core_mask_t done_mask_i,
  output cluster_pkg::data_t      rdata_o,
  output logic                    err_o,
  output cluster_pkg::core_mask_t wake_up_o,
  output cluster_pkg::data_t      eoc_o,
  output logic                    eoc_valid_o
);

  // Writable registers
  cluster_pkg::data_t eoc_q;
  cluster_pkg::data_t wake_up_q;

  // Set for one cycle after an accepted wake-up write
  logic wake_wr_q;

  // Address decode
  logic               hit_eoc;
  logic               hit_wake;
  logic               hit_ro;
  logic               acc_err;
  logic               wr_ok;
  cluster_pkg::data_t rdata_d;

  assign hit_eoc  = (addr_i == cluster_pkg::EocOffset);
  assign hit_wake = (addr_i == cluster_pkg::WakeUpOffset);
  assign hit_ro   = (addr_i == cluster_pkg::TcdmStartOffset) ||
                    (addr_i == cluster_pkg::TcdmEndOffset)   ||
                    (addr_i == cluster_pkg::NumCoresOffset)  ||
                    (addr_i == cluster_pkg::DoneOffset);

  // Unmapped offset, or a write into the read-only part of the map
  assign acc_err = req_i && (!(hit_eoc || hit_wake || hit_ro) || (we_i && hit_ro));
  assign wr_ok   = req_i && we_i && !acc_err;

  // Read data mux
  always_comb begin
    case (addr_i)
      cluster_pkg::EocOffset: begin
        rdata_d = eoc_q;
      end
      cluster_pkg::WakeUpOffset: begin
        rdata_d = wake_up_q;
      end
      cluster_pkg::TcdmStartOffset: begin
        rdata_d = cluster_pkg::TcdmBaseAddr;
      end
      cluster_pkg::TcdmEndOffset: begin
        rdata_d = cluster_pkg::TcdmBaseAddr + cluster_pkg::TcdmSize;
      end
      cluster_pkg::NumCoresOffset: begin
        rdata_d = cluster_pkg::data_t'(cluster_pkg::NumCores);
      end
      cluster_pkg::DoneOffset: begin
        rdata_d = cluster_pkg::data_t'(done_mask_i);
      end
      default: begin
        rdata_d = '0;
      end
    endcase
  end

  // Register writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q     <= cluster_pkg::EocRstVal;
      wake_up_q <= cluster_pkg::WakeUpRstVal;
      wake_wr_q <= 1'b0;
    end else begin
      wake_wr_q <= wr_ok && hit_wake;
      if (wr_ok && hit_eoc) begin
        eoc_q <= wdata_i;
      end
      if (wr_ok && hit_wake) begin
        wake_up_q <= wdata_i;
      end
    end
  end

  // Bus response one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else begin
      err_o <= acc_err;
      if (req_i && !we_i) begin
        rdata_o <= rdata_d;
      end
    end
  end

  // Wake-up value to one-hot core mask, all ones wakes everybody
  always_comb begin
    wake_up_o = '0;
    if (wake_wr_q) begin
      if (wake_up_q < cluster_pkg::data_t'(cluster_pkg::NumCores)) begin
        wake_up_o[wake_up_q[cluster_pkg::CoreIdxWidth-1:0]] = 1'b1;
      end else if (wake_up_q == cluster_pkg::WakeAll) begin
        wake_up_o = '1;
      end
    end
  end

  // Bit 0 flags a valid result, the rest is the result
  assign eoc_o       = eoc_q >> 1;
  assign eoc_valid_o = eoc_q[0];

  // Wake-up mask only in the cycle after a write to the wake-up register
  a_wake_after_write: assert property (
    @(posedge clk_i) disable iff (reset_i)
    |wake_up_o |-> $past(req_i && we_i && hit_wake)
  );

  // Error response only for a request in the previous cycle
  a_err_after_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    err_o |-> $past(req_i)
  );

endmodule

//--- logic/core_sleep_unit.sv
`timescale 1ns/1ns

/*
 * Core sleep unit
 * Models a core that sleeps, wakes, works a fixed time and reports completion
 */
module core_sleep_unit (
  input  logic clk_i,
  input  logic reset_i,
  input  logic wake_i,
  output logic done_o,
  output logic busy_o
);

  cluster_pkg::core_state_e state_q;
  cluster_pkg::run_cnt_t    cnt_q;

  // One wake-up queued while running
  logic pending_q;

  assign busy_o = (state_q == cluster_pkg::RUN);

  // Last run cycle, done pulses as the core leaves the run
  assign done_o = busy_o &&
                  (cnt_q == cluster_pkg::run_cnt_t'(cluster_pkg::WorkCycles - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= cluster_pkg::SLEEP;
      cnt_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      case (state_q)
        cluster_pkg::SLEEP: begin
          if (wake_i) begin
            state_q <= cluster_pkg::RUN;
            cnt_q   <= '0;
          end
        end
        cluster_pkg::RUN: begin
          if (done_o) begin
            cnt_q     <= '0;
            pending_q <= 1'b0;
            // A queued or simultaneous wake-up starts another run
            if (!(pending_q || wake_i)) begin
              state_q <= cluster_pkg::SLEEP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
            if (wake_i) begin
              pending_q <= 1'b1;
            end
          end
        end
        default: begin
          state_q <= cluster_pkg::SLEEP;
        end
      endcase
    end
  end

  // Completion only after at least two cycles of work, never from sleep
  a_done_in_run: assert property (
    @(posedge clk_i) disable iff (reset_i)
    done_o |-> busy_o && $past(busy_o)
  );

  a_cnt_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cnt_q <= cluster_pkg::WorkCycles
  );

endmodule

//--- logic/completion_tracker.sv
`timescale 1ns/1ns

/*
 * Completion tracker
 * Sticky per-core done mask, cleared when a core is woken again
 */
module completion_tracker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  cluster_pkg::core_mask_t wake_i,
  input  cluster_pkg::core_mask_t done_i,
  output cluster_pkg::core_mask_t done_mask_o,
  output logic                    all_done_o
);

  cluster_pkg::core_mask_t mask_q;

  // Wake beats done in the same cycle, since new work has started
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
    end else begin
      mask_q <= (mask_q | done_i) & ~wake_i;
    end
  end

  assign done_mask_o = mask_q;
  assign all_done_o  = &mask_q;

  // All done is only reached through a completion pulse
  a_all_done_rise: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(all_done_o) |-> $past(|done_i)
  );

  // Newly set mask bits come from a done pulse of that core
  a_mask_from_done: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mask_q & ~$past(mask_q) & ~$past(done_i)) == '0
  );

endmodule

//--- logic/cluster_ctrl_top.sv
`timescale 1ns/1ns

/*
 * Cluster control top level
 * Register file, per-core sleep units and completion tracker
 */
module cluster_ctrl_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Register bus
  input  logic                    bus_req_i,
  input  logic                    bus_we_i,
  input  cluster_pkg::addr_t      bus_addr_i,
  input  cluster_pkg::data_t      bus_wdata_i,
  output cluster_pkg::data_t      bus_rdata_o,
  output logic                    bus_err_o,
  // Cluster status
  output cluster_pkg::data_t      eoc_o,
  output logic                    eoc_valid_o,
  output cluster_pkg::core_mask_t done_mask_o,
  output cluster_pkg::core_mask_t busy_o,
  output logic                    all_done_o
);

  cluster_pkg::core_mask_t wake_up;
  cluster_pkg::core_mask_t core_done;

  ctrl_registers u_ctrl_registers (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (bus_req_i),
    .we_i        (bus_we_i),
    .addr_i      (bus_addr_i),
    .wdata_i     (bus_wdata_i),
    .done_mask_i (done_mask_o),
    .rdata_o     (bus_rdata_o),
    .err_o       (bus_err_o),
    .wake_up_o   (wake_up),
    .eoc_o       (eoc_o),
    .eoc_valid_o (eoc_valid_o)
  );

  // One sleep unit per core
  for (genvar i = 0; i < cluster_pkg::NumCores; i++) begin : g_core
    core_sleep_unit u_core (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .wake_i  (wake_up[i]),
      .done_o  (core_done[i]),
      .busy_o  (busy_o[i])
    );
  end

  completion_tracker u_completion_tracker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .wake_i      (wake_up),
    .done_i      (core_done),
    .done_mask_o (done_mask_o),
    .all_done_o  (all_done_o)
  );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

/*
 * Testbench clock and reset generator
 */
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset high for three rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- verification/tb_cluster_ctrl.sv
`timescale 1ns/1ns

/*
 * Testbench for the cluster control block
 * Register bus accesses, core wake-ups, completion mask and end of computation
 */
module tb_cluster_ctrl;

  logic                    clk;
  logic                    reset;
  logic                    bus_req;
  logic                    bus_we;
  cluster_pkg::addr_t      bus_addr;
  cluster_pkg::data_t      bus_wdata;
  cluster_pkg::data_t      bus_rdata;
  logic                    bus_err;
  cluster_pkg::data_t      eoc;
  logic                    eoc_valid;
  cluster_pkg::core_mask_t done_mask;
  cluster_pkg::core_mask_t busy;
  logic                    all_done;

  // Model of the writable registers and of the expected done mask
  cluster_pkg::data_t      model_eoc;
  cluster_pkg::data_t      model_wake;
  cluster_pkg::core_mask_t model_done;

  int unsigned check_count;
  int unsigned error_count;
  int unsigned timeout_count;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  cluster_ctrl_top dut0 (
    .clk_i       (clk),
    .reset_i     (reset),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err),
    .eoc_o       (eoc),
    .eoc_valid_o (eoc_valid),
    .done_mask_o (done_mask),
    .busy_o      (busy),
    .all_done_o  (all_done)
  );

  // Expected read data for an offset
  function automatic cluster_pkg::data_t expected_read(input cluster_pkg::addr_t addr);
    case (addr)
      cluster_pkg::EocOffset:       return model_eoc;
      cluster_pkg::WakeUpOffset:    return model_wake;
      cluster_pkg::TcdmStartOffset: return cluster_pkg::TcdmBaseAddr;
      cluster_pkg::TcdmEndOffset:   return cluster_pkg::TcdmBaseAddr + cluster_pkg::TcdmSize;
      cluster_pkg::NumCoresOffset:  return cluster_pkg::data_t'(cluster_pkg::NumCores);
      cluster_pkg::DoneOffset:      return cluster_pkg::data_t'(model_done);
      default:                      return '0;
    endcase
  endfunction

  // Cores addressed by a value written to the wake-up register
  function automatic cluster_pkg::core_mask_t expected_wake_mask(input cluster_pkg::data_t value);
    if (value < cluster_pkg::NumCores) begin
      return cluster_pkg::core_mask_t'(1) << value;
    end else if (value == '1) begin
      return '1;
    end
    return '0;
  endfunction

  task automatic check_data(input string what, input cluster_pkg::data_t got,
                            input cluster_pkg::data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input string what, input cluster_pkg::core_mask_t got,
                            input cluster_pkg::core_mask_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // One strobe, response sampled on the next falling edge
  task automatic bus_access(input logic we, input cluster_pkg::addr_t addr,
                            input cluster_pkg::data_t wdata,
                            output cluster_pkg::data_t rdata, output logic err);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    @(negedge clk);
    bus_req = 1'b0;
    bus_we  = 1'b0;
    rdata   = bus_rdata;
    err     = bus_err;
  endtask

  task automatic read_check(input cluster_pkg::addr_t addr);
    cluster_pkg::data_t rd;
    logic               err;
    bus_access(1'b0, addr, '0, rd, err);
    check_data($sformatf("read of offset %h", addr), rd, expected_read(addr));
    check_bit($sformatf("error on read of offset %h", addr), err, 1'b0);
  endtask

  task automatic wait_for_done(input cluster_pkg::core_mask_t mask);
    int unsigned              cycles;
    cluster_pkg::core_state_e state;
    cycles = 0;
    while ((done_mask & mask) != mask && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if ((done_mask & mask) != mask) begin
      timeout_count++;
      for (int i = 0; i < cluster_pkg::NumCores; i++) begin
        state = busy[i] ? cluster_pkg::RUN : cluster_pkg::SLEEP;
        $display("Timeout waiting for completion of mask %b, core %0d is in %s",
                 mask, i, state.name());
      end
    end
  endtask

  // Write the wake-up register and follow the cores until they finish
  task automatic wake_and_check(input cluster_pkg::data_t value);
    cluster_pkg::core_mask_t exp_wake;
    cluster_pkg::data_t      rd;
    logic                    err;
    exp_wake = expected_wake_mask(value);
    bus_access(1'b1, cluster_pkg::WakeUpOffset, value, rd, err);
    check_bit("error on wake-up write", err, 1'b0);
    model_wake = value;
    model_done = model_done & ~exp_wake;
    @(negedge clk);
    check_mask("busy after wake-up", busy, exp_wake);
    check_mask("done mask after wake-up", done_mask, model_done);
    check_bit("all done after wake-up", all_done, &model_done);
    if (exp_wake == '0) begin
      repeat (cluster_pkg::WorkCycles + 4) @(negedge clk);
    end else begin
      wait_for_done(exp_wake);
    end
    model_done = model_done | exp_wake;
    check_mask("done mask after completion", done_mask, model_done);
    check_bit("all done after completion", all_done, &model_done);
    read_check(cluster_pkg::DoneOffset);
    read_check(cluster_pkg::WakeUpOffset);
  endtask

  initial begin
    cluster_pkg::addr_t ro_offsets[4];
    cluster_pkg::addr_t bad_offsets[3];
    cluster_pkg::data_t rd;
    cluster_pkg::data_t value;
    logic               err;
    int unsigned        cycles;

    bus_req       = 1'b0;
    bus_we        = 1'b0;
    bus_addr      = '0;
    bus_wdata     = '0;
    model_eoc     = cluster_pkg::EocRstVal;
    model_wake    = cluster_pkg::WakeUpRstVal;
    model_done    = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    void'($urandom(60883));
    ro_offsets  = '{cluster_pkg::TcdmStartOffset, cluster_pkg::TcdmEndOffset,
                    cluster_pkg::NumCoresOffset, cluster_pkg::DoneOffset};
    bad_offsets = '{5'h18, 5'h1C, 5'h02};

    cycles = 0;
    @(negedge clk);
    while (reset && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (reset) begin
      timeout_count++;
      $display("Timeout waiting for reset to be released");
    end

    // State after reset
    check_bit("eoc_valid_o after reset", eoc_valid, 1'b0);
    check_mask("done mask after reset", done_mask, '0);
    for (int a = 0; a < 6; a++) begin
      read_check(cluster_pkg::addr_t'(4 * a));
    end

    // Read-only and unmapped offsets
    foreach (ro_offsets[i]) begin
      bus_access(1'b1, ro_offsets[i], $urandom, rd, err);
      check_bit($sformatf("error on write to read-only %h", ro_offsets[i]), err, 1'b1);
      read_check(ro_offsets[i]);
    end
    foreach (bad_offsets[i]) begin
      bus_access(1'b1, bad_offsets[i], $urandom, rd, err);
      check_bit($sformatf("error on write to unmapped %h", bad_offsets[i]), err, 1'b1);
      bus_access(1'b0, bad_offsets[i], '0, rd, err);
      check_bit($sformatf("error on read of unmapped %h", bad_offsets[i]), err, 1'b1);
    end
    read_check(cluster_pkg::EocOffset);
    read_check(cluster_pkg::WakeUpOffset);

    // Single cores, then values that address nobody
    repeat (4) begin
      wake_and_check($urandom % cluster_pkg::NumCores);
    end
    repeat (2) begin
      wake_and_check(cluster_pkg::NumCores + ($urandom % 1000));
    end

    // Broadcast, then one core again
    wake_and_check(cluster_pkg::WakeAll);
    wake_and_check($urandom % cluster_pkg::NumCores);

    // End of computation register
    repeat (6) begin
      value = $urandom;
      bus_access(1'b1, cluster_pkg::EocOffset, value, rd, err);
      check_bit("error on eoc write", err, 1'b0);
      model_eoc = value;
      check_data("eoc_o", eoc, value >> 1);
      check_bit("eoc_valid_o", eoc_valid, value[0]);
      read_check(cluster_pkg::EocOffset);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim.f
logic/cluster_pkg.sv
logic/ctrl_registers.sv
logic/core_sleep_unit.sv
logic/completion_tracker.sv
logic/cluster_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_cluster_ctrl.sv

//--- Makefile
# Verilator build and run of the cluster control testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_cluster_ctrl
FILELIST := sim.f
BUILD    := obj_dir
PASS_MSG := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
